// ==== axi_pkg.sv ====
// AXI4-Lite bus widths and response encoding for the memory path
package axi_pkg;

  // --------------------------------------------------
  // Bus widths
  // --------------------------------------------------

  // Byte address
  localparam int ADDR_W = 32;

  // One 64-bit beat per transfer
  localparam int DATA_W = 64;

  // One strobe bit per data byte
  localparam int STRB_W = DATA_W / 8;

  // --------------------------------------------------
  // Response codes
  // --------------------------------------------------

  // EXOKAY is not used on AXI4-Lite
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

endpackage

// ==== mem_pkg.sv ====
// Memory window, SRAM geometry and FSM states of the memory path
package mem_pkg;

  // --------------------------------------------------
  // Memory window
  // --------------------------------------------------

  // Reset vector region of the core
  localparam logic [31:0] MEM_BASE = 32'h8000_0000;

  // 1024 words of 64 bits or 8 KiB in total
  localparam int MEM_WORDS = 1024;
  localparam int IDX_W     = 10;

  // --------------------------------------------------
  // FSM states
  // --------------------------------------------------

  typedef enum logic {
    RD_IDLE,
    RD_DATA
  } rd_state_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_e;

  // Grant held until the granted master's R handshake
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_FETCH,
    ARB_LSU
  } arb_state_e;

endpackage

// ==== sram_array.sv ====
// Single-port synchronous SRAM with byte write enables and registered read data
`timescale 1ns/1ns

module sram_array (
  input  logic                         i_aclk,
  input  logic                         i_en,
  input  logic [axi_pkg::STRB_W-1:0]   i_we,
  input  logic [mem_pkg::IDX_W-1:0]    i_idx,
  input  logic [axi_pkg::DATA_W-1:0]   i_wdata,
  output logic [axi_pkg::DATA_W-1:0]   o_rdata
);
  import axi_pkg::*;
  import mem_pkg::*;

  logic [DATA_W-1:0] mem [MEM_WORDS];

  // Write when any strobe is set, otherwise read.
  // o_rdata keeps its value across writes.
  always_ff @(posedge i_aclk) begin
    if (i_en) begin
      if (|i_we) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (i_we[b]) begin
            mem[i_idx][b*8 +: 8] <= i_wdata[b*8 +: 8];
          end
        end
      end else begin
        o_rdata <= mem[i_idx];
      end
    end
  end

endmodule

// ==== axil_sram_slave.sv ====
// AXI4-Lite slave over the SRAM with separate read and write FSMs and address decode
`timescale 1ns/1ns

module axil_sram_slave (
  input  logic                         i_aclk,
  input  logic                         i_rst_n,
  // Read address and data
  input  logic [axi_pkg::ADDR_W-1:0]   i_araddr,
  input  logic                         i_arvalid,
  output logic                         o_arready,
  output logic [axi_pkg::DATA_W-1:0]   o_rdata,
  output axi_pkg::axi_resp_e           o_rresp,
  output logic                         o_rvalid,
  input  logic                         i_rready,
  // Write address and data
  input  logic [axi_pkg::ADDR_W-1:0]   i_awaddr,
  input  logic                         i_awvalid,
  output logic                         o_awready,
  input  logic [axi_pkg::DATA_W-1:0]   i_wdata,
  input  logic [axi_pkg::STRB_W-1:0]   i_wstrb,
  input  logic                         i_wvalid,
  output logic                         o_wready,
  // Write response
  output axi_pkg::axi_resp_e           o_bresp,
  output logic                         o_bvalid,
  input  logic                         i_bready,
  // SRAM side
  output logic                         o_mem_en,
  output logic [axi_pkg::STRB_W-1:0]   o_mem_we,
  output logic [mem_pkg::IDX_W-1:0]    o_mem_idx,
  output logic [axi_pkg::DATA_W-1:0]   o_mem_wdata,
  input  logic [axi_pkg::DATA_W-1:0]   i_mem_rdata
);
  import axi_pkg::*;
  import mem_pkg::*;

  rd_state_e        rd_state;
  wr_state_e        wr_state;
  logic             rd_wait;
  logic             rd_err_q;
  logic [IDX_W-1:0] ar_idx_q;
  logic             aw_ok_q;
  logic [IDX_W-1:0] aw_idx_q;
  logic             ar_fire;
  logic             r_fire;
  logic             aw_fire;
  logic             w_fire;
  logic             b_fire;
  logic             wr_go;
  logic             rd_go;

  function automatic logic in_window(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] off;
    off = addr - MEM_BASE;
    return off < ADDR_W'(MEM_WORDS * STRB_W);
  endfunction

  function automatic logic [IDX_W-1:0] word_idx(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] off;
    off = addr - MEM_BASE;
    return off[$clog2(STRB_W) +: IDX_W];
  endfunction

  assign ar_fire = i_arvalid && o_arready;
  assign r_fire  = o_rvalid && i_rready;
  assign aw_fire = i_awvalid && o_awready;
  assign w_fire  = i_wvalid && o_wready;
  assign b_fire  = o_bvalid && i_bready;

  // Write owns the SRAM port and a colliding read launches a cycle later.
  // Empty strobes would turn into a read and disturb pending R data.
  assign wr_go = w_fire && aw_ok_q && (|i_wstrb);
  assign rd_go = (ar_fire || rd_wait) && !wr_go;

  // --------------------------------------------------
  // Read FSM
  // --------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rd_state <= RD_IDLE;
      rd_wait  <= 1'b0;
    end else begin
      case (rd_state)
        RD_IDLE: if (ar_fire) rd_state <= RD_DATA;
        RD_DATA: if (r_fire) rd_state <= RD_IDLE;
        default: rd_state <= RD_IDLE;
      endcase
      if (ar_fire && wr_go) begin
        rd_wait <= 1'b1;
      end else if (rd_go) begin
        rd_wait <= 1'b0;
      end
    end
  end

  // --------------------------------------------------
  // Write FSM
  // --------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_state <= WR_IDLE;
    end else begin
      case (wr_state)
        WR_IDLE: if (aw_fire) wr_state <= WR_DATA;
        WR_DATA: if (w_fire) wr_state <= WR_RESP;
        WR_RESP: if (b_fire) wr_state <= WR_IDLE;
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  // Decoded addresses
  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      ar_idx_q <= word_idx(i_araddr);
      rd_err_q <= !in_window(i_araddr);
    end
    if (aw_fire) begin
      aw_idx_q <= word_idx(i_awaddr);
      aw_ok_q  <= in_window(i_awaddr);
    end
  end

  assign o_arready = (rd_state == RD_IDLE);
  assign o_rvalid  = (rd_state == RD_DATA) && !rd_wait;
  assign o_rdata   = rd_err_q ? '0 : i_mem_rdata;
  assign o_rresp   = rd_err_q ? RESP_DECERR : RESP_OKAY;

  assign o_awready = (wr_state == WR_IDLE);
  assign o_wready  = (wr_state == WR_DATA);
  assign o_bvalid  = (wr_state == WR_RESP);
  assign o_bresp   = aw_ok_q ? RESP_OKAY : RESP_DECERR;

  assign o_mem_en    = wr_go || rd_go;
  assign o_mem_we    = wr_go ? i_wstrb : '0;
  assign o_mem_idx   = wr_go ? aw_idx_q : (rd_wait ? ar_idx_q : word_idx(i_araddr));
  assign o_mem_wdata = i_wdata;

endmodule

// ==== axil_rd_arbiter.sv ====
// Round-robin arbiter joining the fetch and load/store read channels onto one slave
`timescale 1ns/1ns

module axil_rd_arbiter (
  input  logic                         i_aclk,
  input  logic                         i_rst_n,
  // Fetch master
  input  logic [axi_pkg::ADDR_W-1:0]   i_m0_araddr,
  input  logic                         i_m0_arvalid,
  output logic                         o_m0_arready,
  output logic [axi_pkg::DATA_W-1:0]   o_m0_rdata,
  output axi_pkg::axi_resp_e           o_m0_rresp,
  output logic                         o_m0_rvalid,
  input  logic                         i_m0_rready,
  // Load/store master
  input  logic [axi_pkg::ADDR_W-1:0]   i_m1_araddr,
  input  logic                         i_m1_arvalid,
  output logic                         o_m1_arready,
  output logic [axi_pkg::DATA_W-1:0]   o_m1_rdata,
  output axi_pkg::axi_resp_e           o_m1_rresp,
  output logic                         o_m1_rvalid,
  input  logic                         i_m1_rready,
  // Slave side
  output logic [axi_pkg::ADDR_W-1:0]   o_s_araddr,
  output logic                         o_s_arvalid,
  input  logic                         i_s_arready,
  input  logic [axi_pkg::DATA_W-1:0]   i_s_rdata,
  input  axi_pkg::axi_resp_e           i_s_rresp,
  input  logic                         i_s_rvalid,
  output logic                         o_s_rready
);
  import mem_pkg::*;

  arb_state_e state;
  logic       last_lsu;
  logic       r_done;

  assign r_done = i_s_rvalid && o_s_rready;

  // --------------------------------------------------
  // Grant FSM
  // --------------------------------------------------
  // On a tie the master not served last wins
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state    <= ARB_IDLE;
      last_lsu <= 1'b0;
    end else begin
      case (state)
        ARB_IDLE: begin
          if (i_m0_arvalid && (!i_m1_arvalid || last_lsu)) begin
            state    <= ARB_FETCH;
            last_lsu <= 1'b0;
          end else if (i_m1_arvalid) begin
            state    <= ARB_LSU;
            last_lsu <= 1'b1;
          end
        end
        ARB_FETCH,
        ARB_LSU: if (r_done) state <= ARB_IDLE;
        default: state <= ARB_IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // Channel routing
  // --------------------------------------------------
  // The slave keeps arready low while its one read is pending,
  // so a second AR from the granted master just waits
  always_comb begin
    o_s_araddr   = i_m0_araddr;
    o_s_arvalid  = 1'b0;
    o_s_rready   = 1'b0;
    o_m0_arready = 1'b0;
    o_m1_arready = 1'b0;
    o_m0_rvalid  = 1'b0;
    o_m1_rvalid  = 1'b0;
    case (state)
      ARB_FETCH: begin
        o_s_arvalid  = i_m0_arvalid;
        o_s_rready   = i_m0_rready;
        o_m0_arready = i_s_arready;
        o_m0_rvalid  = i_s_rvalid;
      end
      ARB_LSU: begin
        o_s_araddr   = i_m1_araddr;
        o_s_arvalid  = i_m1_arvalid;
        o_s_rready   = i_m1_rready;
        o_m1_arready = i_s_arready;
        o_m1_rvalid  = i_s_rvalid;
      end
      default: ;
    endcase
  end

  // Data and response are shared and rvalid tells the owner
  assign o_m0_rdata = i_s_rdata;
  assign o_m0_rresp = i_s_rresp;
  assign o_m1_rdata = i_s_rdata;
  assign o_m1_rresp = i_s_rresp;

endmodule

// ==== mem_subsys_top.sv ====
// Memory subsystem top with fetch and load/store AXI4-Lite ports onto one SRAM
`timescale 1ns/1ns

module mem_subsys_top (
  input  logic                         i_aclk,
  input  logic                         i_rst_n,
  // Fetch port, read only
  input  logic [axi_pkg::ADDR_W-1:0]   i_if_araddr,
  input  logic                         i_if_arvalid,
  output logic                         o_if_arready,
  output logic [axi_pkg::DATA_W-1:0]   o_if_rdata,
  output axi_pkg::axi_resp_e           o_if_rresp,
  output logic                         o_if_rvalid,
  input  logic                         i_if_rready,
  // Load/store read port
  input  logic [axi_pkg::ADDR_W-1:0]   i_ls_araddr,
  input  logic                         i_ls_arvalid,
  output logic                         o_ls_arready,
  output logic [axi_pkg::DATA_W-1:0]   o_ls_rdata,
  output axi_pkg::axi_resp_e           o_ls_rresp,
  output logic                         o_ls_rvalid,
  input  logic                         i_ls_rready,
  // Load/store write port
  input  logic [axi_pkg::ADDR_W-1:0]   i_ls_awaddr,
  input  logic                         i_ls_awvalid,
  output logic                         o_ls_awready,
  input  logic [axi_pkg::DATA_W-1:0]   i_ls_wdata,
  input  logic [axi_pkg::STRB_W-1:0]   i_ls_wstrb,
  input  logic                         i_ls_wvalid,
  output logic                         o_ls_wready,
  output axi_pkg::axi_resp_e           o_ls_bresp,
  output logic                         o_ls_bvalid,
  input  logic                         i_ls_bready
);
  import axi_pkg::*;
  import mem_pkg::*;

  // Arbiter to slave read channel
  logic [ADDR_W-1:0] s_araddr;
  logic              s_arvalid;
  logic              s_arready;
  logic [DATA_W-1:0] s_rdata;
  axi_resp_e         s_rresp;
  logic              s_rvalid;
  logic              s_rready;

  // Slave to SRAM
  logic              mem_en;
  logic [STRB_W-1:0] mem_we;
  logic [IDX_W-1:0]  mem_idx;
  logic [DATA_W-1:0] mem_wdata;
  logic [DATA_W-1:0] mem_rdata;

  axil_rd_arbiter u_rd_arb (
    .i_aclk       (i_aclk),
    .i_rst_n      (i_rst_n),
    .i_m0_araddr  (i_if_araddr),
    .i_m0_arvalid (i_if_arvalid),
    .o_m0_arready (o_if_arready),
    .o_m0_rdata   (o_if_rdata),
    .o_m0_rresp   (o_if_rresp),
    .o_m0_rvalid  (o_if_rvalid),
    .i_m0_rready  (i_if_rready),
    .i_m1_araddr  (i_ls_araddr),
    .i_m1_arvalid (i_ls_arvalid),
    .o_m1_arready (o_ls_arready),
    .o_m1_rdata   (o_ls_rdata),
    .o_m1_rresp   (o_ls_rresp),
    .o_m1_rvalid  (o_ls_rvalid),
    .i_m1_rready  (i_ls_rready),
    .o_s_araddr   (s_araddr),
    .o_s_arvalid  (s_arvalid),
    .i_s_arready  (s_arready),
    .i_s_rdata    (s_rdata),
    .i_s_rresp    (s_rresp),
    .i_s_rvalid   (s_rvalid),
    .o_s_rready   (s_rready)
  );

  axil_sram_slave u_slave (
    .i_aclk      (i_aclk),
    .i_rst_n     (i_rst_n),
    .i_araddr    (s_araddr),
    .i_arvalid   (s_arvalid),
    .o_arready   (s_arready),
    .o_rdata     (s_rdata),
    .o_rresp     (s_rresp),
    .o_rvalid    (s_rvalid),
    .i_rready    (s_rready),
    .i_awaddr    (i_ls_awaddr),
    .i_awvalid   (i_ls_awvalid),
    .o_awready   (o_ls_awready),
    .i_wdata     (i_ls_wdata),
    .i_wstrb     (i_ls_wstrb),
    .i_wvalid    (i_ls_wvalid),
    .o_wready    (o_ls_wready),
    .o_bresp     (o_ls_bresp),
    .o_bvalid    (o_ls_bvalid),
    .i_bready    (i_ls_bready),
    .o_mem_en    (mem_en),
    .o_mem_we    (mem_we),
    .o_mem_idx   (mem_idx),
    .o_mem_wdata (mem_wdata),
    .i_mem_rdata (mem_rdata)
  );

  sram_array u_sram (
    .i_aclk  (i_aclk),
    .i_en    (mem_en),
    .i_we    (mem_we),
    .i_idx   (mem_idx),
    .i_wdata (mem_wdata),
    .o_rdata (mem_rdata)
  );

endmodule

// ==== mem_subsys_chk.sv ====
// Bound protocol checks on the response channels of the memory subsystem
`timescale 1ns/1ns

module mem_subsys_chk (
  input logic                       i_aclk,
  input logic                       i_rst_n,
  input logic [axi_pkg::DATA_W-1:0] i_if_rdata,
  input axi_pkg::axi_resp_e         i_if_rresp,
  input logic                       i_if_rvalid,
  input logic                       i_if_rready,
  input logic [axi_pkg::DATA_W-1:0] i_ls_rdata,
  input axi_pkg::axi_resp_e         i_ls_rresp,
  input logic                       i_ls_rvalid,
  input logic                       i_ls_rready,
  input axi_pkg::axi_resp_e         i_ls_bresp,
  input logic                       i_ls_bvalid,
  input logic                       i_ls_bready
);

  int unsigned fails = 0;

  // --------------------------------------------------
  // Response held until accepted
  // --------------------------------------------------
  if_r_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_if_rvalid && !i_if_rready |=>
      i_if_rvalid && $stable(i_if_rdata) && $stable(i_if_rresp))
    else begin
      fails++;
      $error("fetch R response dropped or changed before RREADY");
    end

  ls_r_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_ls_rvalid && !i_ls_rready |=>
      i_ls_rvalid && $stable(i_ls_rdata) && $stable(i_ls_rresp))
    else begin
      fails++;
      $error("load/store R response dropped or changed before RREADY");
    end

  ls_b_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_ls_bvalid && !i_ls_bready |=> i_ls_bvalid && $stable(i_ls_bresp))
    else begin
      fails++;
      $error("B response dropped or changed before BREADY");
    end

  // First cycle out of reset
  quiet_after_reset: assert property (@(posedge i_aclk)
    $rose(i_rst_n) |-> !i_if_rvalid && !i_ls_rvalid && !i_ls_bvalid)
    else begin
      fails++;
      $error("response VALID high in the first cycle after reset");
    end

endmodule

bind mem_subsys_top mem_subsys_chk u_chk (
  .i_aclk      (i_aclk),
  .i_rst_n     (i_rst_n),
  .i_if_rdata  (o_if_rdata),
  .i_if_rresp  (o_if_rresp),
  .i_if_rvalid (o_if_rvalid),
  .i_if_rready (i_if_rready),
  .i_ls_rdata  (o_ls_rdata),
  .i_ls_rresp  (o_ls_rresp),
  .i_ls_rvalid (o_ls_rvalid),
  .i_ls_rready (i_ls_rready),
  .i_ls_bresp  (o_ls_bresp),
  .i_ls_bvalid (o_ls_bvalid),
  .i_ls_bready (i_ls_bready)
);

// ==== tb_mem_subsys.sv ====
// Testbench for the memory subsystem with random traffic on both ports checked against a model
`timescale 1ns/1ns

module tb_mem_subsys;
  import axi_pkg::*;
  import mem_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int N_WR       = 64;
  localparam int N_CONC     = 64;
  localparam int N_OOR      = 16;
  localparam int N_BP       = 32;
  localparam int N_TXN      = 2 * MEM_WORDS + 2 * (N_WR + N_CONC + N_OOR) + 3 * N_BP;
  // Worst case per transaction including stalls and the other port's read
  localparam int TXN_CYCLES = 40;

  logic              aclk;
  logic              rst_n;
  logic [ADDR_W-1:0] if_araddr;
  logic              if_arvalid;
  logic              if_arready;
  logic [DATA_W-1:0] if_rdata;
  axi_resp_e         if_rresp;
  logic              if_rvalid;
  logic              if_rready;
  logic [ADDR_W-1:0] ls_araddr;
  logic              ls_arvalid;
  logic              ls_arready;
  logic [DATA_W-1:0] ls_rdata;
  axi_resp_e         ls_rresp;
  logic              ls_rvalid;
  logic              ls_rready;
  logic [ADDR_W-1:0] ls_awaddr;
  logic              ls_awvalid;
  logic              ls_awready;
  logic [DATA_W-1:0] ls_wdata;
  logic [STRB_W-1:0] ls_wstrb;
  logic              ls_wvalid;
  logic              ls_wready;
  axi_resp_e         ls_bresp;
  logic              ls_bvalid;
  logic              ls_bready;

  logic [DATA_W-1:0] model [MEM_WORDS];
  int checks     = 0;
  int errors     = 0;
  int if_ar_cnt  = 0;
  int if_r_cnt   = 0;
  int ls_ar_cnt  = 0;
  int ls_r_cnt   = 0;
  int if_skipped = 0;
  int ls_skipped = 0;

  mem_subsys_top uut (
    .i_aclk       (aclk),
    .i_rst_n      (rst_n),
    .i_if_araddr  (if_araddr),
    .i_if_arvalid (if_arvalid),
    .o_if_arready (if_arready),
    .o_if_rdata   (if_rdata),
    .o_if_rresp   (if_rresp),
    .o_if_rvalid  (if_rvalid),
    .i_if_rready  (if_rready),
    .i_ls_araddr  (ls_araddr),
    .i_ls_arvalid (ls_arvalid),
    .o_ls_arready (ls_arready),
    .o_ls_rdata   (ls_rdata),
    .o_ls_rresp   (ls_rresp),
    .o_ls_rvalid  (ls_rvalid),
    .i_ls_rready  (ls_rready),
    .i_ls_awaddr  (ls_awaddr),
    .i_ls_awvalid (ls_awvalid),
    .o_ls_awready (ls_awready),
    .i_ls_wdata   (ls_wdata),
    .i_ls_wstrb   (ls_wstrb),
    .i_ls_wvalid  (ls_wvalid),
    .o_ls_wready  (ls_wready),
    .o_ls_bresp   (ls_bresp),
    .o_ls_bvalid  (ls_bvalid),
    .i_ls_bready  (ls_bready)
  );

  initial begin
    aclk = 1'b0;
    forever #(CLK_PERIOD / 2) aclk = ~aclk;
  end

  initial begin
    #(N_TXN * TXN_CYCLES * CLK_PERIOD);
    $display("Timeout: traffic did not finish within %0d cycles", N_TXN * TXN_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  // --------------------------------------------------
  // Handshake counters and fairness monitor
  // --------------------------------------------------
  always @(posedge aclk) begin
    if (rst_n) begin
      if (if_rvalid && if_r_cnt == if_ar_cnt) begin
        errors++;
        $display("ERROR: fetch port got an R response with no read outstanding");
      end
      if (ls_rvalid && ls_r_cnt == ls_ar_cnt) begin
        errors++;
        $display("ERROR: load/store port got an R response with no read outstanding");
      end
      if (if_rvalid && if_rready) if_r_cnt++;
      if (ls_rvalid && ls_rready) ls_r_cnt++;
      if (if_arvalid && if_arready) begin
        if_ar_cnt++;
        if_skipped = 0;
      end else if (if_arvalid && ls_rvalid && ls_rready) begin
        if_skipped++;
      end
      if (ls_arvalid && ls_arready) begin
        ls_ar_cnt++;
        ls_skipped = 0;
      end else if (ls_arvalid && if_rvalid && if_rready) begin
        ls_skipped++;
      end
      if (if_skipped == 3 || ls_skipped == 3) begin
        errors++;
        $display("ERROR: a read port waited for more than two reads of the other port");
      end
    end
  end

  function automatic logic addr_mapped(input logic [ADDR_W-1:0] addr);
    return addr >= MEM_BASE && addr < MEM_BASE + ADDR_W'(MEM_WORDS * 8);
  endfunction

  function automatic logic [ADDR_W-1:0] word_addr(input int idx);
    return MEM_BASE + ADDR_W'(idx * 8);
  endfunction

  // Random aligned address outside the window
  function automatic logic [ADDR_W-1:0] unmapped_addr();
    logic [ADDR_W-1:0] a;
    a = $urandom & ~32'h7;
    if (addr_mapped(a)) a = a ^ 32'h4000_0000;
    return a;
  endfunction

  // Byte lanes with a set strobe take the new data
  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
                                                     input logic [DATA_W-1:0] data,
                                                     input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] res;
    res = old;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) res[b*8 +: 8] = data[b*8 +: 8];
    end
    return res;
  endfunction

  function automatic logic arready_of(input logic lsu);
    return lsu ? ls_arready : if_arready;
  endfunction

  function automatic logic rvalid_of(input logic lsu);
    return lsu ? ls_rvalid : if_rvalid;
  endfunction

  function automatic logic [DATA_W-1:0] rdata_of(input logic lsu);
    return lsu ? ls_rdata : if_rdata;
  endfunction

  function automatic axi_resp_e rresp_of(input logic lsu);
    return lsu ? ls_rresp : if_rresp;
  endfunction

  task automatic compare(input string name, input logic [DATA_W-1:0] expected,
                         input logic [DATA_W-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH %s: expected %h actual %h", name, expected, actual);
    end
  endtask

  // Expect awready high with arreadys and all VALIDs low
  task automatic check_idle_outputs(input string name);
    compare(name, DATA_W'(6'b100000),
            DATA_W'({ls_awready, if_arready, ls_arready, ls_bvalid, ls_rvalid, if_rvalid}));
  endtask

  // --------------------------------------------------
  // Bus tasks entered right after a rising edge
  // --------------------------------------------------
  task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [STRB_W-1:0] strb, input int stall,
                            output axi_resp_e resp);
    axi_resp_e held;
    ls_awaddr  <= addr;
    ls_awvalid <= 1'b1;
    do begin
      @(posedge aclk);
    end while (!ls_awready);
    ls_awvalid <= 1'b0;
    ls_wdata   <= data;
    ls_wstrb   <= strb;
    ls_wvalid  <= 1'b1;
    do begin
      @(posedge aclk);
    end while (!ls_wready);
    ls_wvalid <= 1'b0;
    do begin
      @(posedge aclk);
    end while (!ls_bvalid);
    held = ls_bresp;
    repeat (stall) begin
      @(posedge aclk);
      if (!ls_bvalid || ls_bresp !== held) begin
        errors++;
        $display("ERROR: write response dropped or changed while BREADY was low");
      end
    end
    ls_bready <= 1'b1;
    @(posedge aclk);
    resp = ls_bresp;
    ls_bready <= 1'b0;
  endtask

  task automatic read_word(input logic lsu, input logic [ADDR_W-1:0] addr, input int stall,
                           output logic [DATA_W-1:0] data, output axi_resp_e resp);
    logic [DATA_W-1:0] held;
    if (lsu) begin
      ls_araddr  <= addr;
      ls_arvalid <= 1'b1;
    end else begin
      if_araddr  <= addr;
      if_arvalid <= 1'b1;
    end
    do begin
      @(posedge aclk);
    end while (!arready_of(lsu));
    if (lsu) ls_arvalid <= 1'b0;
    else if_arvalid <= 1'b0;
    do begin
      @(posedge aclk);
    end while (!rvalid_of(lsu));
    held = rdata_of(lsu);
    repeat (stall) begin
      @(posedge aclk);
      if (!rvalid_of(lsu) || rdata_of(lsu) !== held) begin
        errors++;
        $display("ERROR: read data dropped or changed while RREADY was low");
      end
    end
    if (lsu) ls_rready <= 1'b1;
    else if_rready <= 1'b1;
    @(posedge aclk);
    data = rdata_of(lsu);
    resp = rresp_of(lsu);
    if (lsu) ls_rready <= 1'b0;
    else if_rready <= 1'b0;
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] data_if;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] strb;
    logic [ADDR_W-1:0] addr;
    axi_resp_e         resp;
    axi_resp_e         resp_if;
    logic              lsu;
    int                idx;
    int                idx2;
    int                stall;
    int                wr_idx [N_WR];
    int                if_idx [N_CONC];
    int                ls_idx [N_CONC];

    void'($urandom(32'h5914));
    rst_n      <= 1'b0;
    if_araddr  <= '0;
    if_arvalid <= 1'b0;
    if_rready  <= 1'b0;
    ls_araddr  <= '0;
    ls_arvalid <= 1'b0;
    ls_rready  <= 1'b0;
    ls_awaddr  <= '0;
    ls_awvalid <= 1'b0;
    ls_wdata   <= '0;
    ls_wstrb   <= '0;
    ls_wvalid  <= 1'b0;
    ls_bready  <= 1'b0;

    repeat (2) @(posedge aclk);
    check_idle_outputs("reset_held");
    @(posedge aclk);
    rst_n <= 1'b1;
    @(posedge aclk);
    check_idle_outputs("reset_release");

    // Fill every word so all reads have a known value
    for (int i = 0; i < MEM_WORDS; i++) begin
      wdata = {$urandom, $urandom};
      write_word(word_addr(i), wdata, '1, 0, resp);
      model[i] = wdata;
      compare("fill_bresp", DATA_W'(RESP_OKAY), DATA_W'(resp));
    end

    for (int i = 0; i < N_WR; i++) begin
      wr_idx[i] = int'($urandom_range(MEM_WORDS - 1));
      wdata     = {$urandom, $urandom};
      strb      = STRB_W'($urandom_range(255));
      write_word(word_addr(wr_idx[i]), wdata, strb, 0, resp);
      model[wr_idx[i]] = merge_bytes(model[wr_idx[i]], wdata, strb);
      compare("strobe_bresp", DATA_W'(RESP_OKAY), DATA_W'(resp));
    end
    for (int i = 0; i < N_WR; i++) begin
      read_word(1'b1, word_addr(wr_idx[i]), 0, data, resp);
      compare("strobe_rdata", model[wr_idx[i]], data);
      compare("strobe_rresp", DATA_W'(RESP_OKAY), DATA_W'(resp));
    end

    for (int i = 0; i < N_CONC; i++) begin
      if_idx[i] = int'($urandom_range(MEM_WORDS - 1));
      ls_idx[i] = int'($urandom_range(MEM_WORDS - 1));
    end
    fork
      begin
        for (int i = 0; i < N_CONC; i++) begin
          read_word(1'b0, word_addr(if_idx[i]), 0, data_if, resp_if);
          compare("concurrent_if_rdata", model[if_idx[i]], data_if);
          compare("concurrent_if_rresp", DATA_W'(RESP_OKAY), DATA_W'(resp_if));
        end
      end
      begin
        for (int i = 0; i < N_CONC; i++) begin
          read_word(1'b1, word_addr(ls_idx[i]), 0, data, resp);
          compare("concurrent_ls_rdata", model[ls_idx[i]], data);
          compare("concurrent_ls_rresp", DATA_W'(RESP_OKAY), DATA_W'(resp));
        end
      end
    join
    repeat (2) @(posedge aclk);
    compare("if_r_per_ar", DATA_W'(if_ar_cnt), DATA_W'(if_r_cnt));
    compare("ls_r_per_ar", DATA_W'(ls_ar_cnt), DATA_W'(ls_r_cnt));

    // Both window edges first and random unmapped addresses after
    for (int i = 0; i < N_OOR; i++) begin
      if (i == 0) addr = MEM_BASE - 32'd8;
      else if (i == 1) addr = MEM_BASE + ADDR_W'(MEM_WORDS * 8);
      else addr = unmapped_addr();
      write_word(addr, {$urandom, $urandom}, '1, 0, resp);
      compare("oor_bresp", DATA_W'(RESP_DECERR), DATA_W'(resp));
      read_word(i[0], addr, 0, data, resp);
      compare("oor_rdata", '0, data);
      compare("oor_rresp", DATA_W'(RESP_DECERR), DATA_W'(resp));
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      read_word(i[0], word_addr(i), 0, data, resp);
      compare("readback_rdata", model[i], data);
      compare("readback_rresp", DATA_W'(RESP_OKAY), DATA_W'(resp));
    end

    for (int i = 0; i < N_BP; i++) begin
      idx   = int'($urandom_range(MEM_WORDS - 1));
      idx2  = (idx + 1 + int'($urandom_range(MEM_WORDS - 2))) % MEM_WORDS;
      wdata = {$urandom, $urandom};
      strb  = STRB_W'($urandom_range(255));
      stall = int'($urandom_range(8, 1));
      // Fetch AR lands on the same cycle as the W handshake
      fork
        write_word(word_addr(idx), wdata, strb, stall, resp);
        read_word(1'b0, word_addr(idx2), 0, data_if, resp_if);
      join
      model[idx] = merge_bytes(model[idx], wdata, strb);
      compare("stall_bresp", DATA_W'(RESP_OKAY), DATA_W'(resp));
      compare("collide_rdata", model[idx2], data_if);
      compare("collide_rresp", DATA_W'(RESP_OKAY), DATA_W'(resp_if));
      lsu = 1'($urandom_range(1));
      read_word(lsu, word_addr(idx), int'($urandom_range(8, 1)), data, resp);
      compare("stall_rdata", model[idx], data);
      compare("stall_rresp", DATA_W'(RESP_OKAY), DATA_W'(resp));
    end

    repeat (2) @(posedge aclk);
    $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, uut.u_chk.fails);
    if (errors == 0 && uut.u_chk.fails == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
axi_pkg.sv
mem_pkg.sv
sram_array.sv
axil_sram_slave.sv
axil_rd_arbiter.sv
mem_subsys_top.sv
mem_subsys_chk.sv
tb_mem_subsys.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the memory subsystem testbench with Verilator, run it, and search for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
  --top-module tb_mem_subsys -f verilog.f -o sim_tb \
  && ./obj_dir/sim_tb +verilator+error+limit+1000 | tee /dev/stderr \
  | grep -q "SIMULATION PASSED" \
  && { echo "run_sim: pass"; exit 0; } \
  || { echo "run_sim: fail"; exit 1; }
